/* all.f */
+incdir+logic
logic/wg_pkg.sv
logic/dport_if.sv
logic/dport_req_stage.sv
logic/hart_router.sv
logic/hart_debug_unit.sv
logic/dport_resp_stage.sv
logic/workgroup_dbg.sv
dv/tb_workgroup_dbg.sv

/* dv/tb_workgroup_dbg.sv */
// Self-checking testbench for the workgroup debug top level, compiled from all.f as the top module
`timescale 1ns/100ps
`include "wg_defines.svh"

module tb_workgroup_dbg;

localparam int hart_count = 3;    // Slot 3 has no unit

logic        clk = 1'b0;
logic        reset;
logic [1:0]  hartsel;
logic        haltreq;
logic        resumereq;
logic [3:0]  msip;
logic [3:0]  mtip;
logic [3:0]  meip;
logic [3:0]  seip;
logic        req_valid;
logic        req_ready;
logic [1:0]  req_hartsel;
logic        req_kind;
logic [15:0] req_addr;
logic [63:0] req_wdata;
logic        resp_valid;
logic        resp_ready;
logic        resp_error;
logic [63:0] resp_rdata;
logic [3:0]  halted;
logic [3:0]  available;

// Reference model state
logic [63:0] ref_gpr [4][32];
logic [63:0] ref_dscratch [4];
logic [3:0]  ref_halted;
logic [64:0] drv_exp;             // {error, rdata} expected for the request on the port
logic        check_latency;

// Expected responses in acceptance order
logic [64:0] exp_mem [64];
int          acc_cycle [64];
logic        timed [64];
logic [5:0]  wr_ptr;
logic [5:0]  rd_ptr;
int          cycle;
int          stall_cnt;

// Values captured at the rising edge, checked at the falling edge
logic        acc_q;
logic        hs_q;
logic        pend_q;
logic        timed_q;
logic [64:0] got_q;
logic [64:0] want_q;
int          lat_q;

logic        bp_on;
logic        bp_on_q;
logic        bp_pat [96];
int          bp_idx;
logic [31:0] lfsr = 32'h1322_8d71;
string       test_name;
int          mismatches;
int          failures;
logic        timed_out = 1'b0;

always #2 clk = ~clk;

workgroup_dbg #(
    .cpu_num(hart_count)
) DUT (
    .i_clk(clk),
    .i_reset(reset),
    .i_hartsel(hartsel),
    .i_haltreq(haltreq),
    .i_resumereq(resumereq),
    .i_msip(msip),
    .i_mtip(mtip),
    .i_meip(meip),
    .i_seip(seip),
    .i_req_valid(req_valid),
    .o_req_ready(req_ready),
    .i_req_hartsel(req_hartsel),
    .i_req_kind(req_kind),
    .i_req_addr(req_addr),
    .i_req_wdata(req_wdata),
    .o_resp_valid(resp_valid),
    .i_resp_ready(resp_ready),
    .o_resp_error(resp_error),
    .o_resp_rdata(resp_rdata),
    .o_halted(halted),
    .o_available(available)
);

always @(posedge clk) begin
    cycle   <= cycle + 1;
    bp_on_q <= bp_on;
    acc_q   <= req_valid && req_ready;
    hs_q    <= resp_valid && resp_ready;
    got_q   <= {resp_error, resp_rdata};
    want_q  <= exp_mem[rd_ptr];
    timed_q <= timed[rd_ptr];
    lat_q   <= cycle - acc_cycle[rd_ptr];
    pend_q  <= rd_ptr != wr_ptr;
    if (reset) begin
        wr_ptr     <= '0;
        rd_ptr     <= '0;
        ref_halted <= '0;
    end else begin
        if (req_valid && req_ready) begin
            exp_mem[wr_ptr]   <= drv_exp;
            acc_cycle[wr_ptr] <= cycle;
            timed[wr_ptr]     <= check_latency;
            wr_ptr            <= wr_ptr + 1'b1;
        end
        if (resp_valid && resp_ready) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
        if (req_valid && !req_ready) begin
            stall_cnt <= stall_cnt + 1;
        end
        if (haltreq && hartsel < hart_count) begin
            ref_halted[hartsel] <= 1'b1;    // Halt beats resume
        end else if (resumereq && hartsel < hart_count) begin
            ref_halted[hartsel] <= 1'b0;
        end
    end
end

// Debugger stalls the response port in random stretches
always @(negedge clk) begin
    if (bp_on_q) begin
        resp_ready = bp_pat[bp_idx];
        bp_idx     = (bp_idx + 1) % 96;
    end else begin
        resp_ready = 1'b1;
    end
end

a_no_extra: assert property (@(negedge clk) disable iff (reset) hs_q |-> pend_q)
    else begin
        failures++;
        $display("Response arrived with no request outstanding in %s", test_name);
    end

a_resp_data: assert property (@(negedge clk) disable iff (reset)
    hs_q && pend_q |-> got_q == want_q)
    else begin
        mismatches++;
        $display("Mismatch %s: expected %h actual %h", test_name, want_q, got_q);
    end

a_latency: assert property (@(negedge clk) disable iff (reset)
    hs_q && pend_q && timed_q |-> lat_q == 3)
    else begin
        mismatches++;
        $display("Mismatch %s latency: expected 3 actual %0d", test_name, lat_q);
    end

a_halted: assert property (@(negedge clk) disable iff (reset) halted == ref_halted)
    else begin
        mismatches++;
        $display("Mismatch %s halted: expected %b actual %b", test_name, ref_halted, halted);
    end

a_available: assert property (@(negedge clk) disable iff (reset) available == 4'b0111)
    else begin
        mismatches++;
        $display("Mismatch %s available: expected 0111 actual %b", test_name, available);
    end

a_in_flight: assert property (@(negedge clk) disable iff (reset) 6'(wr_ptr - rd_ptr) <= 6'd3)
    else begin
        failures++;
        $display("More than 3 requests in flight in %s", test_name);
    end

// Taps 32, 22, 2, 1
function automatic logic next_bit();
    logic fb;
    fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    return fb;
endfunction

function automatic logic [63:0] rand_word(input int nbits);
    logic [63:0] w;
    w = '0;
    for (int i = 0; i < nbits; i++) begin
        w = {w[62:0], next_bit()};
    end
    return w;
endfunction

function automatic logic [15:0] gpr_addr(input logic [4:0] idx);
    return {4'd0, 7'd0, idx};
endfunction

function automatic logic [15:0] csr_addr(input logic [11:0] idx);
    return {4'd1, idx};
endfunction

// Applies the access rules to the model and returns {error, rdata}
function automatic logic [64:0] model_access(input int hart, input logic kind,
                                             input logic [15:0] addr, input logic [63:0] wdata);
    logic [3:0]  region;
    logic [4:0]  gidx;
    logic [11:0] cidx;
    region = addr[15:12];
    gidx   = addr[4:0];
    cidx   = addr[11:0];
    if (hart >= hart_count || !ref_halted[hart]) begin
        return {1'b1, 64'd0};
    end
    if (region == 4'd0) begin
        if (kind) begin
            if (gidx != 5'd0) begin
                ref_gpr[hart][gidx] = wdata;
            end
            return 65'd0;
        end
        return {1'b0, (gidx == 5'd0) ? 64'd0 : ref_gpr[hart][gidx]};
    end
    if (region != 4'd1) begin
        return {1'b1, 64'd0};
    end
    case (cidx)
        12'd0: begin
            if (kind) begin
                ref_dscratch[hart] = wdata;
                return 65'd0;
            end
            return {1'b0, ref_dscratch[hart]};
        end
        12'd1: return kind ? {1'b1, 64'd0} :
                      {1'b0, 60'd0, seip[hart], meip[hart], mtip[hart], msip[hart]};
        12'd2: return kind ? {1'b1, 64'd0} : {1'b0, 64'(hart)};
        default: return {1'b1, 64'd0};
    endcase
endfunction

// Later requests and drains are skipped once a wait has timed out
task automatic flag_timeout(input string why);
    $display("%s in %s", why, test_name);
    failures++;
    timed_out = 1'b1;
    req_valid = 1'b0;
endtask

// Offers one request and returns on the falling edge after it was taken
task automatic issue(input logic [1:0] hart, input logic kind,
                     input logic [15:0] addr, input logic [63:0] wdata);
    logic done;
    if (timed_out) begin
        return;
    end
    req_valid   = 1'b1;
    req_hartsel = hart;
    req_kind    = kind;
    req_addr    = addr;
    req_wdata   = wdata;
    drv_exp     = model_access(hart, kind, addr, wdata);
    done        = 1'b0;
    for (int n = 0; n < 50 && !done; n++) begin
        @(negedge clk);
        done = acc_q;
    end
    if (!done) begin
        flag_timeout("Request not accepted within 50 cycles");
    end
endtask

task automatic drain();
    int n;
    req_valid = 1'b0;
    if (timed_out) begin
        return;
    end
    n = 0;
    while (rd_ptr != wr_ptr && n < 50) begin
        @(negedge clk);
        n++;
    end
    if (rd_ptr != wr_ptr) begin
        flag_timeout("Responses still outstanding after 50 cycles");
    end
endtask

task automatic pulse_ctrl(input logic [1:0] hart, input logic halt, input logic resume);
    hartsel   = hart;
    haltreq   = halt;
    resumereq = resume;
    @(negedge clk);
    haltreq   = 1'b0;
    resumereq = 1'b0;
    @(negedge clk);
endtask

task automatic fill_stall_pattern();
    int   idx;
    int   len;
    logic lvl;
    idx = 0;
    lvl = 1'b0;
    while (idx < 96) begin
        len = 1 + int'(rand_word(3));
        for (int k = 0; k < len && idx < 96; k++) begin
            bp_pat[idx] = lvl;
            idx++;
        end
        lvl = !lvl;
    end
endtask

initial begin : main_proc
    logic [4:0] idx [8];
    for (int h = 0; h < 4; h++) begin
        ref_dscratch[h] = '0;
        for (int r = 0; r < 32; r++) begin
            ref_gpr[h][r] = '0;
        end
    end
    {hartsel, haltreq, resumereq} = '0;
    {msip, mtip, meip, seip}      = '0;
    {req_valid, req_hartsel, req_kind, req_addr, req_wdata} = '0;
    resp_ready    = 1'b1;
    check_latency = 1'b1;
    bp_on         = 1'b0;
    test_name     = "reset";
    reset         = 1'b1;
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    issue(2'd0, 1'b0, gpr_addr(5'd1), 64'd0);    // Not halted yet
    drain();

    test_name = "halt";
    pulse_ctrl(2'd0, 1'b1, 1'b0);
    pulse_ctrl(2'd0, 1'b0, 1'b1);
    pulse_ctrl(2'd1, 1'b1, 1'b1);
    pulse_ctrl(2'd0, 1'b1, 1'b0);
    pulse_ctrl(2'd2, 1'b1, 1'b0);
    pulse_ctrl(2'd3, 1'b1, 1'b0);

    test_name = "gpr";
    for (int h = 0; h < hart_count; h++) begin
        for (int k = 0; k < 8; k++) begin
            idx[k] = 5'(rand_word(5));
            issue(2'(h), 1'b1, gpr_addr(idx[k]), rand_word(64));
        end
        issue(2'(h), 1'b1, gpr_addr(5'd0), rand_word(64));
        issue(2'(h), 1'b0, gpr_addr(5'd0), 64'd0);
        for (int k = 0; k < 8; k++) begin
            issue(2'(h), 1'b0, gpr_addr(idx[k]), 64'd0);
        end
    end
    drain();

    test_name = "csr";
    msip = 4'(rand_word(4));
    mtip = 4'(rand_word(4));
    meip = 4'(rand_word(4));
    seip = 4'(rand_word(4));
    for (int h = 0; h < hart_count; h++) begin
        issue(2'(h), 1'b0, csr_addr(`WG_CSR_HARTID), 64'd0);
        issue(2'(h), 1'b0, csr_addr(`WG_CSR_IRQ), 64'd0);
        issue(2'(h), 1'b1, csr_addr(`WG_CSR_DSCRATCH), rand_word(64));
        issue(2'(h), 1'b0, csr_addr(`WG_CSR_DSCRATCH), 64'd0);
        issue(2'(h), 1'b1, csr_addr(`WG_CSR_HARTID), rand_word(64));
        issue(2'(h), 1'b0, csr_addr(12'h7), 64'd0);
        issue(2'(h), 1'b0, {4'h5, 12'h0}, 64'd0);
    end
    drain();

    test_name = "unavailable";
    issue(2'd3, 1'b0, gpr_addr(5'd1), 64'd0);
    issue(2'd3, 1'b1, csr_addr(`WG_CSR_DSCRATCH), rand_word(64));
    drain();

    test_name = "backpressure";
    fill_stall_pattern();
    check_latency = 1'b0;
    bp_on         = 1'b1;
    for (int k = 0; k < 30; k++) begin
        issue(2'(rand_word(2)), 1'(rand_word(1)), gpr_addr(5'(rand_word(5))), rand_word(64));
    end
    bp_on = 1'b0;
    drain();
    check_latency = 1'b1;

    assert (stall_cnt > 0)
        else begin
            failures++;
            $display("Request port never stalled under back-pressure");
        end
    $display("Error counts: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
        $display("All tests passed");
    end else begin
        $display("Some tests failed");
    end
    $finish;
end : main_proc

endmodule: tb_workgroup_dbg

/* logic/workgroup_dbg.sv */
// Top level of the workgroup debug subsystem, connects the dport pipeline to the hart units
`timescale 1ns/100ps
`include "wg_defines.svh"

module workgroup_dbg import wg_pkg::*; #(
    parameter int unsigned cpu_num = `WG_CPU_MAX
) (
    input logic                        i_clk,
    input logic                        i_reset,
    input logic [`WG_LOG2_CPU_MAX-1:0] i_hartsel,       // Target of halt and resume
    input logic                        i_haltreq,
    input logic                        i_resumereq,
    input logic [`WG_CPU_MAX-1:0]      i_msip,
    input logic [`WG_CPU_MAX-1:0]      i_mtip,
    input logic [`WG_CPU_MAX-1:0]      i_meip,
    input logic [`WG_CPU_MAX-1:0]      i_seip,
    input logic                        i_req_valid,
    output logic                       o_req_ready,
    input logic [`WG_LOG2_CPU_MAX-1:0] i_req_hartsel,
    input logic                        i_req_kind,      // 1 for write
    input logic [`WG_ADDR_W-1:0]       i_req_addr,
    input logic [`WG_DATA_W-1:0]       i_req_wdata,
    output logic                       o_resp_valid,
    input logic                        i_resp_ready,
    output logic                       o_resp_error,
    output logic [`WG_DATA_W-1:0]      o_resp_rdata,
    output logic [`WG_CPU_MAX-1:0]     o_halted,
    output logic [`WG_CPU_MAX-1:0]     o_available
);

dport_req_t             req;
dport_resp_t            resp;
logic [`WG_CPU_MAX-1:0] haltreq;
logic [`WG_CPU_MAX-1:0] resumereq;
logic [3:0]             irq [`WG_CPU_MAX];

dport_if #(.payload_t(dport_req_t))  req_bus ();
dport_if #(.payload_t(dport_req_t))  hart_req [`WG_CPU_MAX] ();
dport_if #(.payload_t(dport_resp_t)) hart_resp [`WG_CPU_MAX] ();
dport_if #(.payload_t(dport_resp_t)) resp_bus ();

always_comb begin : comb_proc
    req.hartsel = i_req_hartsel;
    req.kind    = dport_kind_e'(i_req_kind);
    req.addr    = i_req_addr;
    req.wdata   = i_req_wdata;
    for (int i = 0; i < `WG_CPU_MAX; i++) begin
        haltreq[i]   = i_haltreq && (i_hartsel == i);
        resumereq[i] = i_resumereq && (i_hartsel == i);
        irq[i]       = {i_seip[i], i_meip[i], i_mtip[i], i_msip[i]};
    end
end : comb_proc

dport_req_stage req_stage0 (
    .i_clk(i_clk),
    .i_reset(i_reset),
    .i_valid(i_req_valid),
    .o_ready(o_req_ready),
    .i_req(req),
    .o_out(req_bus)
);

hart_router #(
    .cpu_num(cpu_num)
) router0 (
    .i_clk(i_clk),
    .i_reset(i_reset),
    .i_req(req_bus),
    .o_hart_req(hart_req),
    .i_hart_resp(hart_resp),
    .o_resp(resp_bus),
    .o_available(o_available)
);

for (genvar i = 0; i < cpu_num; i++) begin : xslothart
    hart_debug_unit #(
        .hartid(i)
    ) hartx (
        .i_clk(i_clk),
        .i_reset(i_reset),
        .i_haltreq(haltreq[i]),
        .i_resumereq(resumereq[i]),
        .i_irq(irq[i]),
        .i_req(hart_req[i]),
        .o_resp(hart_resp[i]),
        .o_halted(o_halted[i])
    );
end : xslothart

// Empty slots stay idle and never report halted
for (genvar i = cpu_num; i < `WG_CPU_MAX; i++) begin : xemptyslot
    assign hart_req[i].ready    = 1'b0;
    assign hart_resp[i].valid   = 1'b0;
    assign hart_resp[i].payload = '0;
    assign o_halted[i]          = 1'b0;
end : xemptyslot

dport_resp_stage resp_stage0 (
    .i_clk(i_clk),
    .i_reset(i_reset),
    .i_in(resp_bus),
    .o_valid(o_resp_valid),
    .i_ready(i_resp_ready),
    .o_resp(resp)
);

assign o_resp_error = resp.error;
assign o_resp_rdata = resp.rdata;

endmodule: workgroup_dbg

/* logic/dport_resp_stage.sv */
// Exit stage of the debug pipeline, holds one response for the top-level ports under back-pressure
`timescale 1ns/100ps

module dport_resp_stage import wg_pkg::*; (
    input logic         i_clk,
    input logic         i_reset,
    dport_if.sink       i_in,       // Merged hart results
    output logic        o_valid,
    input logic         i_ready,
    output dport_resp_t o_resp
);

logic        valid_q;
dport_resp_t resp_q;

assign i_in.ready = !valid_q || i_ready;

always_ff @(posedge i_clk) begin
    if (i_reset) begin
        valid_q <= 1'b0;
    end else if (i_in.ready) begin
        valid_q <= i_in.valid;
    end
end

// Held while the debugger stalls
always_ff @(posedge i_clk) begin
    if (i_in.valid && i_in.ready) begin
        resp_q <= i_in.payload;
    end
end

assign o_valid = valid_q;
assign o_resp  = resp_q;

endmodule: dport_resp_stage

/* logic/hart_debug_unit.sv */
// Per-hart debug target holding halt state, GPRs and debug CSRs, one access per cycle
`timescale 1ns/100ps
`include "wg_defines.svh"

module hart_debug_unit import wg_pkg::*; #(
    parameter int unsigned hartid = 0
) (
    input logic       i_clk,
    input logic       i_reset,
    input logic       i_haltreq,
    input logic       i_resumereq,
    input logic [3:0] i_irq,          // {seip, meip, mtip, msip}
    dport_if.sink     i_req,
    dport_if.source   o_resp,
    output logic      o_halted
);

localparam logic [`WG_DATA_W-1:0] hartid_word = hartid;

logic                  halted_q;
logic [`WG_DATA_W-1:0] gpr_q [`WG_GPR_NUM];
logic [`WG_DATA_W-1:0] dscratch_q;
logic                  res_valid_q;
dport_resp_t           res_q;
dport_req_t            req;
logic                  accept;
logic                  is_write;
logic                  acc_error;
logic                  wr_gpr;
logic                  wr_dscratch;
logic [`WG_DATA_W-1:0] rd_data;

assign req      = i_req.payload;
assign accept   = i_req.valid && i_req.ready;
assign is_write = req.kind == DPORT_WRITE;

// Halt request has priority over resume
always_ff @(posedge i_clk) begin
    if (i_reset) begin
        halted_q <= 1'b0;
    end else if (i_haltreq) begin
        halted_q <= 1'b1;
    end else if (i_resumereq) begin
        halted_q <= 1'b0;
    end
end

always_comb begin : decode_proc
    acc_error   = 1'b0;
    wr_gpr      = 1'b0;
    wr_dscratch = 1'b0;
    rd_data     = '0;
    if (!halted_q) begin
        acc_error = 1'b1;                       // Access only while halted
    end else if (req.addr.gpr.region == DPORT_REGION_GPR) begin
        wr_gpr = is_write && (req.addr.gpr.index != '0);
        if (req.addr.gpr.index != '0) begin
            rd_data = gpr_q[req.addr.gpr.index];
        end
    end else if (req.addr.csr.region == DPORT_REGION_CSR) begin
        case (req.addr.csr.index)
            12'(`WG_CSR_DSCRATCH): begin
                wr_dscratch = is_write;
                rd_data     = dscratch_q;
            end
            12'(`WG_CSR_IRQ): begin
                acc_error = is_write;
                rd_data   = {{(`WG_DATA_W-4){1'b0}}, i_irq};
            end
            12'(`WG_CSR_HARTID): begin
                acc_error = is_write;
                rd_data   = hartid_word;
            end
            default: acc_error = 1'b1;          // Unknown CSR
        endcase
    end else begin
        acc_error = 1'b1;                       // Invalid region
    end
    if (acc_error || is_write) begin
        rd_data = '0;
    end
end : decode_proc

// Architectural state, zeroed by reset
always_ff @(posedge i_clk) begin
    if (i_reset) begin
        for (int i = 0; i < `WG_GPR_NUM; i++) begin
            gpr_q[i] <= '0;
        end
        dscratch_q <= '0;
    end else if (accept && !acc_error) begin
        if (wr_gpr) begin
            gpr_q[req.addr.gpr.index] <= req.wdata;
        end
        if (wr_dscratch) begin
            dscratch_q <= req.wdata;
        end
    end
end

// Result slot
assign i_req.ready = !res_valid_q || o_resp.ready;

always_ff @(posedge i_clk) begin
    if (i_reset) begin
        res_valid_q <= 1'b0;
    end else if (i_req.ready) begin
        res_valid_q <= i_req.valid;
    end
end

always_ff @(posedge i_clk) begin
    if (accept) begin
        res_q.error <= acc_error;
        res_q.rdata <= rd_data;
    end
end

assign o_resp.valid   = res_valid_q;
assign o_resp.payload = res_q;
assign o_halted       = halted_q;

endmodule: hart_debug_unit

/* logic/hart_router.sv */
// Steers each request to its hart unit or the local error slot and merges the results in order
`timescale 1ns/100ps
`include "wg_defines.svh"

module hart_router import wg_pkg::*; #(
    parameter int unsigned cpu_num = `WG_CPU_MAX
) (
    input logic                   i_clk,
    input logic                   i_reset,
    dport_if.sink                 i_req,
    dport_if.source               o_hart_req [`WG_CPU_MAX],
    dport_if.sink                 i_hart_resp [`WG_CPU_MAX],
    dport_if.source               o_resp,
    output logic [`WG_CPU_MAX-1:0] o_available
);

logic                   slot_free;    // Result stage can take one more item
logic                   err_sel;      // Selected slot has no hart unit
logic                   err_valid_q;
logic [`WG_CPU_MAX-1:0] hart_ready;
logic [`WG_CPU_MAX-1:0] resp_valid;
dport_resp_t            resp_payload [`WG_CPU_MAX];
dport_resp_t            merged;

// Hart result slots and the error slot act as one stage, so only one holds an item
assign slot_free = !o_resp.valid || o_resp.ready;
assign err_sel   = i_req.payload.hartsel >= cpu_num;

for (genvar i = 0; i < `WG_CPU_MAX; i++) begin : g_slot
    if (i < cpu_num) begin : g_unit
        assign o_hart_req[i].valid   = i_req.valid && slot_free
                                       && (i_req.payload.hartsel == i);
        assign o_hart_req[i].payload = i_req.payload;
        assign hart_ready[i]         = o_hart_req[i].ready;
        assign resp_valid[i]         = i_hart_resp[i].valid;
        assign resp_payload[i]       = i_hart_resp[i].payload;
        assign i_hart_resp[i].ready  = o_resp.ready;
        assign o_available[i]        = 1'b1;
    end : g_unit
    else begin : g_none
        assign o_hart_req[i].valid   = 1'b0;
        assign o_hart_req[i].payload = '0;
        assign hart_ready[i]         = 1'b0;
        assign resp_valid[i]         = 1'b0;
        assign resp_payload[i]       = '0;
        assign i_hart_resp[i].ready  = 1'b0;
        assign o_available[i]        = 1'b0;
    end : g_none
end : g_slot

always_comb begin : ready_proc
    if (err_sel) begin
        i_req.ready = slot_free;
    end else begin
        i_req.ready = slot_free && hart_ready[i_req.payload.hartsel];
    end
end : ready_proc

// Error answer carries a fixed payload, only its presence is stored
always_ff @(posedge i_clk) begin
    if (i_reset) begin
        err_valid_q <= 1'b0;
    end else if (slot_free) begin
        err_valid_q <= i_req.valid && err_sel;
    end
end

always_comb begin : merge_proc
    merged.error = 1'b1;        // Error slot answer
    merged.rdata = '0;
    for (int i = 0; i < `WG_CPU_MAX; i++) begin
        if (resp_valid[i]) begin
            merged = resp_payload[i];
        end
    end
end : merge_proc

assign o_resp.valid   = err_valid_q || (|resp_valid);
assign o_resp.payload = merged;

endmodule: hart_router

/* logic/dport_req_stage.sv */
// Entry stage of the debug pipeline, registers a request from the top-level ports onto the link
`timescale 1ns/100ps

module dport_req_stage import wg_pkg::*; (
    input logic       i_clk,
    input logic       i_reset,
    input logic       i_valid,     // Request offered on the plain ports
    output logic      o_ready,
    input dport_req_t i_req,
    dport_if.source   o_out        // Toward the hart router
);

logic       valid_q;
dport_req_t req_q;

// Room when empty or when the held item leaves this cycle
assign o_ready = !valid_q || o_out.ready;

always_ff @(posedge i_clk) begin
    if (i_reset) begin
        valid_q <= 1'b0;
    end else if (o_ready) begin
        valid_q <= i_valid;
    end
end

// Payload only loads on an accepted request
always_ff @(posedge i_clk) begin
    if (i_valid && o_ready) begin
        req_q <= i_req;
    end
end

assign o_out.valid   = valid_q;
assign o_out.payload = req_q;

endmodule: dport_req_stage

/* logic/dport_if.sv */
// Valid/ready channel between debug pipeline stages, instantiated per request or response link
`timescale 1ns/100ps

interface dport_if #(
    parameter type payload_t = logic
);

logic     valid;      // Item offered by the source
logic     ready;      // Sink takes the item this cycle
payload_t payload;    // Held stable while valid waits

// Upstream end of the link
modport source (
    output valid,
    output payload,
    input  ready
);

// Downstream end of the link
modport sink (
    input  valid,
    input  payload,
    output ready
);

endinterface: dport_if

/* logic/wg_pkg.sv */
// Debug port types shared by all workgroup debug stages, imported in module headers
`include "wg_defines.svh"

package wg_pkg;

typedef enum logic {
    DPORT_READ  = 1'b0,
    DPORT_WRITE = 1'b1
} dport_kind_e;

// Upper address nibble selects the register space
typedef enum logic [3:0] {
    DPORT_REGION_GPR = 4'd0,
    DPORT_REGION_CSR = 4'd1
} dport_region_e;

// Same address word seen as a GPR access or as a CSR access
typedef union packed {
    struct packed {
        dport_region_e region;
        logic [6:0]    rsvd;
        logic [4:0]    index;
    } gpr;
    struct packed {
        dport_region_e region;
        logic [11:0]   index;
    } csr;
} dport_addr_u;

typedef struct packed {
    logic [`WG_LOG2_CPU_MAX-1:0] hartsel;
    dport_kind_e                 kind;
    dport_addr_u                 addr;
    logic [`WG_DATA_W-1:0]       wdata;
} dport_req_t;

typedef struct packed {
    logic                  error;
    logic [`WG_DATA_W-1:0] rdata;
} dport_resp_t;

endpackage: wg_pkg

/* logic/wg_defines.svh */
// Workgroup debug sizing and CSR index macros, included by the package and by sized RTL files
`ifndef WG_DEFINES_SVH
`define WG_DEFINES_SVH

// Hart slots in the workgroup
`define WG_CPU_MAX       4
`define WG_LOG2_CPU_MAX  2

// Debug port word sizes
`define WG_DATA_W        64
`define WG_ADDR_W        16

// Architectural state per hart
`define WG_GPR_NUM       32

// CSR view indices
`define WG_CSR_DSCRATCH  0    // Read/write scratch
`define WG_CSR_IRQ       1    // Pending interrupt lines, read only
`define WG_CSR_HARTID    2    // Own hart index, read only

`endif
